// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int INSN_COUNT = 15;
    localparam int REG_ADDR_W = 5;

    // Bit positions in the one-hot class vector.
    localparam int IDX_LUI   = 0;
    localparam int IDX_AUIPC = 1;
    localparam int IDX_JAL   = 2;
    localparam int IDX_JALR  = 3;
    localparam int IDX_BEQ   = 4;
    localparam int IDX_BNE   = 5;
    localparam int IDX_BLT   = 6;
    localparam int IDX_LW    = 7;
    localparam int IDX_SW    = 8;
    localparam int IDX_ADDI  = 9;
    localparam int IDX_ADD   = 10;
    localparam int IDX_SUB   = 11;
    localparam int IDX_OR    = 12;
    localparam int IDX_AND   = 13;
    localparam int IDX_XOR   = 14;

    typedef logic [INSN_COUNT-1:0] insn_class_t;

    // Fixed in every format.
    localparam int RD_LSB   = 7;
    localparam int RS1_LSB  = 15;
    localparam int RS2_LSB  = 20;
    localparam int SIGN_BIT = 31;

    // U and J types match on the opcode alone.
    localparam logic [XLEN-1:0] MASK_LUI    = 32'h0000_007f;
    localparam logic [XLEN-1:0] MATCH_LUI   = 32'h0000_0037;
    localparam logic [XLEN-1:0] MASK_AUIPC  = 32'h0000_007f;
    localparam logic [XLEN-1:0] MATCH_AUIPC = 32'h0000_0017;
    localparam logic [XLEN-1:0] MASK_JAL    = 32'h0000_007f;
    localparam logic [XLEN-1:0] MATCH_JAL   = 32'h0000_006f;
    // Opcode and funct3.
    localparam logic [XLEN-1:0] MASK_JALR   = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_JALR  = 32'h0000_0067;
    localparam logic [XLEN-1:0] MASK_BEQ    = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BEQ   = 32'h0000_0063;
    localparam logic [XLEN-1:0] MASK_BNE    = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BNE   = 32'h0000_1063;
    localparam logic [XLEN-1:0] MASK_BLT    = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BLT   = 32'h0000_4063;
    localparam logic [XLEN-1:0] MASK_LW     = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_LW    = 32'h0000_2003;
    localparam logic [XLEN-1:0] MASK_SW     = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_SW    = 32'h0000_2023;
    localparam logic [XLEN-1:0] MASK_ADDI   = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_ADDI  = 32'h0000_0013;
    // R-type adds funct7.
    localparam logic [XLEN-1:0] MASK_ADD    = 32'hfe00_707f;
    localparam logic [XLEN-1:0] MATCH_ADD   = 32'h0000_0033;
    localparam logic [XLEN-1:0] MASK_SUB    = 32'hfe00_707f;
    localparam logic [XLEN-1:0] MATCH_SUB   = 32'h4000_0033;
    localparam logic [XLEN-1:0] MASK_OR     = 32'hfe00_707f;
    localparam logic [XLEN-1:0] MATCH_OR    = 32'h0000_6033;
    localparam logic [XLEN-1:0] MASK_AND    = 32'hfe00_707f;
    localparam logic [XLEN-1:0] MATCH_AND   = 32'h0000_7033;
    localparam logic [XLEN-1:0] MASK_XOR    = 32'hfe00_707f;
    localparam logic [XLEN-1:0] MATCH_XOR   = 32'h0000_4033;

endpackage

`default_nettype wire

// ==== rtl/uop_pkg.sv ====
`default_nettype none

package uop_pkg;

    localparam int TAG_W      = 4;
    localparam int ALU_OP_W   = 3;
    localparam int OPND_SEL_W = 2;
    localparam int WB_SEL_W   = 2;
    localparam int BRANCH_W   = 3;
    localparam int MEM_OP_W   = 2;

    // ALU_PASS forwards operand 2 unchanged.
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_XOR, ALU_PASS
    } alu_op_t;

    // Zero comes first, a cleared micro-op selects no operand.
    typedef enum logic [OPND_SEL_W-1:0] {
        OPND_ZERO, OPND_REG, OPND_IMM, OPND_PC
    } opnd_sel_t;

    typedef enum logic [WB_SEL_W-1:0] {
        WB_NONE, WB_ALU, WB_MEM, WB_PC4
    } wb_sel_t;

    typedef enum logic [BRANCH_W-1:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_JAL, BR_JALR
    } branch_t;

    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NONE, MEM_LW, MEM_SW
    } mem_op_t;

endpackage

`default_nettype wire

// ==== rtl/insn_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_match (
    input  logic [isa_pkg::XLEN-1:0] insn_i,
    input  logic                     active_i,
    output isa_pkg::insn_class_t     insn_class_o,
    output logic                     illegal_o
);
    import isa_pkg::*;

    function automatic logic hit(input logic [XLEN-1:0] insn,
                                 input logic [XLEN-1:0] mask,
                                 input logic [XLEN-1:0] pattern);
        return (insn & mask) == pattern;
    endfunction

    always_comb begin
        insn_class_o[IDX_LUI]   = hit(insn_i, MASK_LUI, MATCH_LUI);
        insn_class_o[IDX_AUIPC] = hit(insn_i, MASK_AUIPC, MATCH_AUIPC);
        insn_class_o[IDX_JAL]   = hit(insn_i, MASK_JAL, MATCH_JAL);
        insn_class_o[IDX_JALR]  = hit(insn_i, MASK_JALR, MATCH_JALR);
        insn_class_o[IDX_BEQ]   = hit(insn_i, MASK_BEQ, MATCH_BEQ);
        insn_class_o[IDX_BNE]   = hit(insn_i, MASK_BNE, MATCH_BNE);
        insn_class_o[IDX_BLT]   = hit(insn_i, MASK_BLT, MATCH_BLT);
        insn_class_o[IDX_LW]    = hit(insn_i, MASK_LW, MATCH_LW);
        insn_class_o[IDX_SW]    = hit(insn_i, MASK_SW, MATCH_SW);
        insn_class_o[IDX_ADDI]  = hit(insn_i, MASK_ADDI, MATCH_ADDI);
        insn_class_o[IDX_ADD]   = hit(insn_i, MASK_ADD, MATCH_ADD);
        insn_class_o[IDX_SUB]   = hit(insn_i, MASK_SUB, MATCH_SUB);
        insn_class_o[IDX_OR]    = hit(insn_i, MASK_OR, MATCH_OR);
        insn_class_o[IDX_AND]   = hit(insn_i, MASK_AND, MATCH_AND);
        insn_class_o[IDX_XOR]   = hit(insn_i, MASK_XOR, MATCH_XOR);
        // Nothing is classified while inactive.
        if (!active_i) begin
            insn_class_o = '0;
        end
    end

    assign illegal_o = active_i && !(|insn_class_o);

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [isa_pkg::XLEN-1:0] insn_i,
    input  isa_pkg::insn_class_t     insn_class_i,
    output logic [isa_pkg::XLEN-1:0] imm_o
);
    import isa_pkg::*;

    logic sign;
    logic fmt_i;
    logic fmt_s;
    logic fmt_b;
    logic fmt_u;
    logic fmt_j;

    assign sign  = insn_i[SIGN_BIT];
    assign fmt_i = insn_class_i[IDX_ADDI] | insn_class_i[IDX_LW] | insn_class_i[IDX_JALR];
    assign fmt_s = insn_class_i[IDX_SW];
    assign fmt_b = insn_class_i[IDX_BEQ] | insn_class_i[IDX_BNE] | insn_class_i[IDX_BLT];
    assign fmt_u = insn_class_i[IDX_LUI] | insn_class_i[IDX_AUIPC];
    assign fmt_j = insn_class_i[IDX_JAL];

    always_comb begin
        if (fmt_i) begin
            imm_o = {{(XLEN-12){sign}}, insn_i[31:20]};
        end else if (fmt_s) begin
            imm_o = {{(XLEN-12){sign}}, insn_i[31:25], insn_i[11:7]};
        end else if (fmt_b) begin
            imm_o = {{(XLEN-12){sign}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
        end else if (fmt_u) begin
            imm_o = {insn_i[31:12], 12'b0};
        end else if (fmt_j) begin
            imm_o = {{(XLEN-20){sign}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
        end else begin
            // R-type and unclassified words.
            imm_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uop_encode.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_encode (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           hold_i,
    input  logic [isa_pkg::XLEN-1:0]       insn_i,
    input  logic [isa_pkg::XLEN-1:0]       pc_i,
    input  logic                           taken_i,
    input  isa_pkg::insn_class_t           insn_class_i,
    input  logic                           illegal_i,
    input  logic [isa_pkg::XLEN-1:0]       imm_i,
    input  logic [uop_pkg::TAG_W-1:0]      tag_i,
    output logic                           uop_valid_o,
    output logic                           uop_illegal_o,
    output logic [isa_pkg::XLEN-1:0]       uop_pc_o,
    output logic [uop_pkg::TAG_W-1:0]      uop_tag_o,
    output logic                           uop_taken_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rs1_o,
    output logic                           uop_rs1_en_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rs2_o,
    output logic                           uop_rs2_en_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rd_o,
    output logic                           uop_rd_alloc_o,
    output logic [isa_pkg::XLEN-1:0]       uop_imm_o,
    output uop_pkg::alu_op_t               uop_alu_op_o,
    output uop_pkg::opnd_sel_t             uop_op1_sel_o,
    output uop_pkg::opnd_sel_t             uop_op2_sel_o,
    output uop_pkg::wb_sel_t               uop_wb_sel_o,
    output uop_pkg::branch_t               uop_branch_o,
    output uop_pkg::mem_op_t               uop_mem_o
);
    import isa_pkg::*;
    import uop_pkg::*;

    logic      valid_d;
    logic      is_rtype;
    logic      is_branch;
    logic      rs1_en_d;
    logic      rs2_en_d;
    logic      rd_alloc_d;
    alu_op_t   alu_op_d;
    opnd_sel_t op1_sel_d;
    opnd_sel_t op2_sel_d;
    wb_sel_t   wb_sel_d;
    branch_t   branch_d;
    mem_op_t   mem_d;

    assign valid_d   = |insn_class_i;
    assign is_rtype  = insn_class_i[IDX_ADD] | insn_class_i[IDX_SUB] | insn_class_i[IDX_OR]
                     | insn_class_i[IDX_AND] | insn_class_i[IDX_XOR];
    assign is_branch = insn_class_i[IDX_BEQ] | insn_class_i[IDX_BNE] | insn_class_i[IDX_BLT];

    assign rs1_en_d   = is_rtype | is_branch | insn_class_i[IDX_JALR] | insn_class_i[IDX_LW]
                      | insn_class_i[IDX_SW] | insn_class_i[IDX_ADDI];
    assign rs2_en_d   = is_rtype | is_branch | insn_class_i[IDX_SW];
    assign rd_alloc_d = is_rtype | insn_class_i[IDX_LUI] | insn_class_i[IDX_AUIPC]
                      | insn_class_i[IDX_JAL] | insn_class_i[IDX_JALR]
                      | insn_class_i[IDX_LW] | insn_class_i[IDX_ADDI];

    // Class is one-hot, so item order only matters for the fallbacks.
    always_comb begin
        case (1'b1)
            insn_class_i[IDX_LUI]: alu_op_d = ALU_PASS;
            insn_class_i[IDX_SUB]: alu_op_d = ALU_SUB;
            insn_class_i[IDX_OR]:  alu_op_d = ALU_OR;
            insn_class_i[IDX_AND]: alu_op_d = ALU_AND;
            insn_class_i[IDX_XOR]: alu_op_d = ALU_XOR;
            is_branch:             alu_op_d = ALU_NONE;
            valid_d:               alu_op_d = ALU_ADD;
            default:               alu_op_d = ALU_NONE;
        endcase

        case (1'b1)
            insn_class_i[IDX_AUIPC], insn_class_i[IDX_JAL]: op1_sel_d = OPND_PC;
            rs1_en_d:                                       op1_sel_d = OPND_REG;
            default:                                        op1_sel_d = OPND_ZERO;
        endcase

        // SW reads rs2 as store data, its address takes the immediate.
        case (1'b1)
            rs2_en_d && !insn_class_i[IDX_SW]: op2_sel_d = OPND_REG;
            valid_d:                           op2_sel_d = OPND_IMM;
            default:                           op2_sel_d = OPND_ZERO;
        endcase

        case (1'b1)
            insn_class_i[IDX_JAL], insn_class_i[IDX_JALR]: wb_sel_d = WB_PC4;
            insn_class_i[IDX_LW]:                          wb_sel_d = WB_MEM;
            insn_class_i[IDX_SW], is_branch:               wb_sel_d = WB_NONE;
            valid_d:                                       wb_sel_d = WB_ALU;
            default:                                       wb_sel_d = WB_NONE;
        endcase

        case (1'b1)
            insn_class_i[IDX_BEQ]:  branch_d = BR_BEQ;
            insn_class_i[IDX_BNE]:  branch_d = BR_BNE;
            insn_class_i[IDX_BLT]:  branch_d = BR_BLT;
            insn_class_i[IDX_JAL]:  branch_d = BR_JAL;
            insn_class_i[IDX_JALR]: branch_d = BR_JALR;
            default:                branch_d = BR_NONE;
        endcase

        case (1'b1)
            insn_class_i[IDX_LW]: mem_d = MEM_LW;
            insn_class_i[IDX_SW]: mem_d = MEM_SW;
            default:              mem_d = MEM_NONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            uop_valid_o    <= 1'b0;
            uop_illegal_o  <= 1'b0;
            uop_tag_o      <= '0;
            uop_taken_o    <= 1'b0;
            uop_rs1_en_o   <= 1'b0;
            uop_rs2_en_o   <= 1'b0;
            uop_rd_alloc_o <= 1'b0;
            uop_alu_op_o   <= ALU_NONE;
            uop_op1_sel_o  <= OPND_ZERO;
            uop_op2_sel_o  <= OPND_ZERO;
            uop_wb_sel_o   <= WB_NONE;
            uop_branch_o   <= BR_NONE;
            uop_mem_o      <= MEM_NONE;
        end else if (!hold_i) begin
            uop_valid_o    <= valid_d;
            uop_illegal_o  <= illegal_i;
            uop_taken_o    <= taken_i && valid_d;
            uop_rs1_en_o   <= rs1_en_d;
            uop_rs2_en_o   <= rs2_en_d;
            uop_rd_alloc_o <= rd_alloc_d;
            uop_alu_op_o   <= alu_op_d;
            uop_op1_sel_o  <= op1_sel_d;
            uop_op2_sel_o  <= op2_sel_d;
            uop_wb_sel_o   <= wb_sel_d;
            uop_branch_o   <= branch_d;
            uop_mem_o      <= mem_d;
            // Tag of the last valid micro-op.
            if (valid_d) begin
                uop_tag_o <= tag_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            uop_pc_o  <= pc_i;
            uop_imm_o <= imm_i;
            uop_rs1_o <= rs1_en_d ? insn_i[RS1_LSB +: REG_ADDR_W] : '0;
            uop_rs2_o <= rs2_en_d ? insn_i[RS2_LSB +: REG_ADDR_W] : '0;
            uop_rd_o  <= rd_alloc_d ? insn_i[RD_LSB +: REG_ADDR_W] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      fetch_valid_i,
    input  logic                      flush_i,
    input  logic                      stall_i,
    input  isa_pkg::insn_class_t      insn_class_i,
    output logic                      active_o,
    output logic                      hold_o,
    output logic [uop_pkg::TAG_W-1:0] tag_o
);

    logic tag_adv;

    assign active_o = fetch_valid_i && !flush_i;

    // Stall wins over flush, the register holds whatever it had.
    assign hold_o = stall_i;

    // Class is already zero for flushed or invalid words.
    assign tag_adv = (|insn_class_i) && !stall_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tag_o <= '0;
        end else if (tag_adv) begin
            tag_o <= tag_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic [isa_pkg::XLEN-1:0]       fetch_insn_i,
    input  logic [isa_pkg::XLEN-1:0]       fetch_pc_i,
    input  logic                           fetch_valid_i,
    input  logic                           fetch_taken_i,
    input  logic                           flush_i,
    input  logic                           stall_i,
    output logic                           uop_valid_o,
    output logic                           uop_illegal_o,
    output logic [isa_pkg::XLEN-1:0]       uop_pc_o,
    output logic [uop_pkg::TAG_W-1:0]      uop_tag_o,
    output logic                           uop_taken_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rs1_o,
    output logic                           uop_rs1_en_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rs2_o,
    output logic                           uop_rs2_en_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] uop_rd_o,
    output logic                           uop_rd_alloc_o,
    output logic [isa_pkg::XLEN-1:0]       uop_imm_o,
    output uop_pkg::alu_op_t               uop_alu_op_o,
    output uop_pkg::opnd_sel_t             uop_op1_sel_o,
    output uop_pkg::opnd_sel_t             uop_op2_sel_o,
    output uop_pkg::wb_sel_t               uop_wb_sel_o,
    output uop_pkg::branch_t               uop_branch_o,
    output uop_pkg::mem_op_t               uop_mem_o
);
    import isa_pkg::*;
    import uop_pkg::*;

    logic             active;
    logic             hold;
    logic             illegal;
    insn_class_t      insn_class;
    logic [XLEN-1:0]  imm;
    logic [TAG_W-1:0] tag;

    decode_ctrl u_ctrl (
        .clk_i,
        .rstn_i,
        .fetch_valid_i,
        .flush_i,
        .stall_i,
        .insn_class_i (insn_class),
        .active_o     (active),
        .hold_o       (hold),
        .tag_o        (tag)
    );

    insn_match u_match (
        .insn_i       (fetch_insn_i),
        .active_i     (active),
        .insn_class_o (insn_class),
        .illegal_o    (illegal)
    );

    imm_gen u_imm (
        .insn_i       (fetch_insn_i),
        .insn_class_i (insn_class),
        .imm_o        (imm)
    );

    // Micro-op outputs share their names with the top-level ports.
    uop_encode u_encode (
        .clk_i,
        .rstn_i,
        .hold_i       (hold),
        .insn_i       (fetch_insn_i),
        .pc_i         (fetch_pc_i),
        .taken_i      (fetch_taken_i),
        .insn_class_i (insn_class),
        .illegal_i    (illegal),
        .imm_i        (imm),
        .tag_i        (tag),
        .*
    );

endmodule

`default_nettype wire

// ==== test/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
    import isa_pkg::*;
    import uop_pkg::*;

    localparam int MAX_CYCLES = 500;

    logic                  clk_i;
    logic                  rstn_i;
    logic [XLEN-1:0]       fetch_insn_i;
    logic [XLEN-1:0]       fetch_pc_i;
    logic                  fetch_valid_i;
    logic                  fetch_taken_i;
    logic                  flush_i;
    logic                  stall_i;
    logic                  uop_valid_o;
    logic                  uop_illegal_o;
    logic [XLEN-1:0]       uop_pc_o;
    logic [TAG_W-1:0]      uop_tag_o;
    logic                  uop_taken_o;
    logic [REG_ADDR_W-1:0] uop_rs1_o;
    logic                  uop_rs1_en_o;
    logic [REG_ADDR_W-1:0] uop_rs2_o;
    logic                  uop_rs2_en_o;
    logic [REG_ADDR_W-1:0] uop_rd_o;
    logic                  uop_rd_alloc_o;
    logic [XLEN-1:0]       uop_imm_o;
    alu_op_t               uop_alu_op_o;
    opnd_sel_t             uop_op1_sel_o;
    opnd_sel_t             uop_op2_sel_o;
    wb_sel_t               uop_wb_sel_o;
    branch_t               uop_branch_o;
    mem_op_t               uop_mem_o;

    // Stimulus table with one entry per cycle.
    logic [XLEN-1:0] insn_q[$];
    logic [XLEN-1:0] pc_q[$];
    bit              valid_q[$];
    bit              flush_q[$];
    bit              stall_q[$];
    bit              taken_q[$];

    // Expected state of the output register.
    logic                  exp_valid;
    logic                  exp_illegal;
    logic [XLEN-1:0]       exp_pc;
    logic [TAG_W-1:0]      exp_tag;
    logic                  exp_taken;
    logic [REG_ADDR_W-1:0] exp_rs1;
    logic                  exp_rs1_en;
    logic [REG_ADDR_W-1:0] exp_rs2;
    logic                  exp_rs2_en;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  exp_rd_alloc;
    logic [XLEN-1:0]       exp_imm;
    alu_op_t               exp_alu;
    opnd_sel_t             exp_op1;
    opnd_sel_t             exp_op2;
    wb_sel_t               exp_wb;
    branch_t               exp_br;
    mem_op_t               exp_mem;
    logic [TAG_W-1:0]      next_tag;

    integer seed;
    int     errors;
    logic   done;

    decode_stage i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] mask_of(input int k);
        case (k)
            IDX_LUI:   return MASK_LUI;
            IDX_AUIPC: return MASK_AUIPC;
            IDX_JAL:   return MASK_JAL;
            IDX_JALR:  return MASK_JALR;
            IDX_BEQ:   return MASK_BEQ;
            IDX_BNE:   return MASK_BNE;
            IDX_BLT:   return MASK_BLT;
            IDX_LW:    return MASK_LW;
            IDX_SW:    return MASK_SW;
            IDX_ADDI:  return MASK_ADDI;
            IDX_ADD:   return MASK_ADD;
            IDX_SUB:   return MASK_SUB;
            IDX_OR:    return MASK_OR;
            IDX_AND:   return MASK_AND;
            default:   return MASK_XOR;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] match_of(input int k);
        case (k)
            IDX_LUI:   return MATCH_LUI;
            IDX_AUIPC: return MATCH_AUIPC;
            IDX_JAL:   return MATCH_JAL;
            IDX_JALR:  return MATCH_JALR;
            IDX_BEQ:   return MATCH_BEQ;
            IDX_BNE:   return MATCH_BNE;
            IDX_BLT:   return MATCH_BLT;
            IDX_LW:    return MATCH_LW;
            IDX_SW:    return MATCH_SW;
            IDX_ADDI:  return MATCH_ADDI;
            IDX_ADD:   return MATCH_ADD;
            IDX_SUB:   return MATCH_SUB;
            IDX_OR:    return MATCH_OR;
            IDX_AND:   return MATCH_AND;
            default:   return MATCH_XOR;
        endcase
    endfunction

    // Index of the matching instruction or -1 for none.
    function automatic int classify(input logic [XLEN-1:0] w);
        for (int k = 0; k < INSN_COUNT; k++) begin
            if ((w & mask_of(k)) == match_of(k)) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [XLEN-1:0] expected_imm(input logic [XLEN-1:0] w, input byte fmt);
        case (fmt)
            "I":     return {{20{w[31]}}, w[31:20]};
            "S":     return {{20{w[31]}}, w[31:25], w[11:7]};
            "B":     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            "U":     return {w[31:12], 12'h000};
            default: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        endcase
    endfunction

    // Fixed bits from the pattern, random registers and immediate.
    function automatic logic [XLEN-1:0] gen_insn(input int k);
        return match_of(k) | ($random(seed) & ~mask_of(k));
    endfunction

    function automatic bit rand_bit();
        return $random(seed) & 1;
    endfunction

    task automatic add_row(input logic [XLEN-1:0] w, input bit valid, input bit flush,
                           input bit stall, input bit taken, input logic [XLEN-1:0] pc);
        insn_q.push_back(w);
        valid_q.push_back(valid);
        flush_q.push_back(flush);
        stall_q.push_back(stall);
        taken_q.push_back(taken);
        pc_q.push_back(pc);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] pc;
        pc = 32'h0000_1000;
        for (int k = 0; k < INSN_COUNT; k++) begin
            add_row(gen_insn(k), 1, 0, 0, rand_bit(), pc);
            pc += 4;
        end
        // Opcode zero, then ADD with a funct7 of one.
        add_row($random(seed) & 32'hffff_ff80, 1, 0, 0, 1, pc);
        add_row(MATCH_ADD | 32'h0200_0000 | ($random(seed) & ~MASK_ADD), 1, 0, 0, 0, pc + 4);
        add_row(gen_insn(IDX_ADD), 0, 0, 0, 1, pc + 8);
        add_row(gen_insn(IDX_SUB), 1, 1, 0, 1, pc + 12);
        pc += 16;
        // Valid micro-op that the stall has to keep.
        add_row(gen_insn(IDX_XOR), 1, 0, 0, 1, pc);
        pc += 4;
        // Held word across a stall, flushed while stalled, then released.
        w = gen_insn(IDX_LW);
        add_row(w, 1, 0, 1, 1, pc);
        add_row(w, 1, 1, 1, 1, pc);
        add_row(w, 1, 0, 0, 1, pc);
        pc += 4;
        for (int k = INSN_COUNT - 1; k >= 0; k--) begin
            add_row(gen_insn(k), 1, 0, 0, rand_bit(), pc);
            pc += 4;
        end
        add_row(32'hffff_ffff, 1, 0, 0, 0, pc);
    endtask

    task automatic drive_row(input int r);
        fetch_insn_i  <= insn_q[r];
        fetch_pc_i    <= pc_q[r];
        fetch_valid_i <= valid_q[r];
        fetch_taken_i <= taken_q[r];
        flush_i       <= flush_q[r];
        stall_i       <= stall_q[r];
    endtask

    task automatic drive_idle();
        fetch_insn_i  <= '0;
        fetch_pc_i    <= '0;
        fetch_valid_i <= 1'b0;
        fetch_taken_i <= 1'b0;
        flush_i       <= 1'b0;
        stall_i       <= 1'b0;
    endtask

    task automatic set_regs(input bit rs1_en, input bit rs2_en, input bit rd_alloc);
        exp_rs1_en   = rs1_en;
        exp_rs2_en   = rs2_en;
        exp_rd_alloc = rd_alloc;
    endtask

    task automatic set_ctrl(input alu_op_t alu, input opnd_sel_t op1, input opnd_sel_t op2,
                            input wb_sel_t wb);
        exp_alu = alu;
        exp_op1 = op1;
        exp_op2 = op2;
        exp_wb  = wb;
    endtask

    task automatic predict_row(input int r);
        logic [XLEN-1:0] w;
        logic            active;
        int              idx;
        w      = insn_q[r];
        active = valid_q[r] && !flush_q[r];
        idx    = active ? classify(w) : -1;
        // A stalled row leaves the expected state untouched.
        if (!stall_q[r]) begin
            exp_valid   = (idx >= 0);
            exp_illegal = active && (idx < 0);
            exp_pc      = pc_q[r];
            exp_taken   = taken_q[r] && exp_valid;
            exp_imm     = '0;
            exp_br      = BR_NONE;
            exp_mem     = MEM_NONE;
            set_regs(0, 0, 0);
            set_ctrl(ALU_NONE, OPND_ZERO, OPND_ZERO, WB_NONE);
            case (idx)
                IDX_LUI: begin
                    set_regs(0, 0, 1);
                    set_ctrl(ALU_PASS, OPND_ZERO, OPND_IMM, WB_ALU);
                    exp_imm = expected_imm(w, "U");
                end
                IDX_AUIPC: begin
                    set_regs(0, 0, 1);
                    set_ctrl(ALU_ADD, OPND_PC, OPND_IMM, WB_ALU);
                    exp_imm = expected_imm(w, "U");
                end
                IDX_JAL: begin
                    set_regs(0, 0, 1);
                    set_ctrl(ALU_ADD, OPND_PC, OPND_IMM, WB_PC4);
                    exp_imm = expected_imm(w, "J");
                    exp_br  = BR_JAL;
                end
                IDX_JALR: begin
                    set_regs(1, 0, 1);
                    set_ctrl(ALU_ADD, OPND_REG, OPND_IMM, WB_PC4);
                    exp_imm = expected_imm(w, "I");
                    exp_br  = BR_JALR;
                end
                IDX_BEQ, IDX_BNE, IDX_BLT: begin
                    set_regs(1, 1, 0);
                    set_ctrl(ALU_NONE, OPND_REG, OPND_REG, WB_NONE);
                    exp_imm = expected_imm(w, "B");
                    exp_br  = (idx == IDX_BEQ) ? BR_BEQ : (idx == IDX_BNE) ? BR_BNE : BR_BLT;
                end
                IDX_LW: begin
                    set_regs(1, 0, 1);
                    set_ctrl(ALU_ADD, OPND_REG, OPND_IMM, WB_MEM);
                    exp_imm = expected_imm(w, "I");
                    exp_mem = MEM_LW;
                end
                IDX_SW: begin
                    set_regs(1, 1, 0);
                    set_ctrl(ALU_ADD, OPND_REG, OPND_IMM, WB_NONE);
                    exp_imm = expected_imm(w, "S");
                    exp_mem = MEM_SW;
                end
                IDX_ADDI: begin
                    set_regs(1, 0, 1);
                    set_ctrl(ALU_ADD, OPND_REG, OPND_IMM, WB_ALU);
                    exp_imm = expected_imm(w, "I");
                end
                IDX_ADD, IDX_SUB, IDX_OR, IDX_AND, IDX_XOR: begin
                    set_regs(1, 1, 1);
                    set_ctrl((idx == IDX_ADD) ? ALU_ADD : (idx == IDX_SUB) ? ALU_SUB :
                             (idx == IDX_OR) ? ALU_OR : (idx == IDX_AND) ? ALU_AND : ALU_XOR,
                             OPND_REG, OPND_REG, WB_ALU);
                end
                default: begin
                end
            endcase
            exp_rs1 = exp_rs1_en ? w[19:15] : '0;
            exp_rs2 = exp_rs2_en ? w[24:20] : '0;
            exp_rd  = exp_rd_alloc ? w[11:7] : '0;
            if (exp_valid) begin
                exp_tag  = next_tag;
                next_tag = next_tag + 1'b1;
            end
        end
    endtask

    task automatic compare_field(input string where, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s %s is %h, expected %h", $time, where, name, got, exp);
        end
    endtask

    task automatic check_outputs(input int r);
        string where;
        where = $sformatf("row %0d", r);
        compare_field(where, "valid", uop_valid_o, exp_valid);
        compare_field(where, "illegal", uop_illegal_o, exp_illegal);
        compare_field(where, "pc", uop_pc_o, exp_pc);
        compare_field(where, "tag", uop_tag_o, exp_tag);
        compare_field(where, "taken", uop_taken_o, exp_taken);
        compare_field(where, "rs1", uop_rs1_o, exp_rs1);
        compare_field(where, "rs1_en", uop_rs1_en_o, exp_rs1_en);
        compare_field(where, "rs2", uop_rs2_o, exp_rs2);
        compare_field(where, "rs2_en", uop_rs2_en_o, exp_rs2_en);
        compare_field(where, "rd", uop_rd_o, exp_rd);
        compare_field(where, "rd_alloc", uop_rd_alloc_o, exp_rd_alloc);
        compare_field(where, "imm", uop_imm_o, exp_imm);
        compare_field(where, "alu_op", uop_alu_op_o, exp_alu);
        compare_field(where, "op1_sel", uop_op1_sel_o, exp_op1);
        compare_field(where, "op2_sel", uop_op2_sel_o, exp_op2);
        compare_field(where, "wb_sel", uop_wb_sel_o, exp_wb);
        compare_field(where, "branch", uop_branch_o, exp_br);
        compare_field(where, "mem", uop_mem_o, exp_mem);
    endtask

    initial begin
        seed          = 64;
        errors        = 0;
        done          = 1'b0;
        next_tag      = '0;
        exp_tag       = '0;
        rstn_i        = 1'b0;
        fetch_insn_i  = '0;
        fetch_pc_i    = '0;
        fetch_valid_i = 1'b0;
        fetch_taken_i = 1'b0;
        flush_i       = 1'b0;
        stall_i       = 1'b0;
        build_table();

        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        compare_field("after reset", "valid", uop_valid_o, 1'b0);
        compare_field("after reset", "illegal", uop_illegal_o, 1'b0);
        compare_field("after reset", "tag", uop_tag_o, '0);
        compare_field("after reset", "branch", uop_branch_o, BR_NONE);

        // Row r is captured on the edge that drives row r+1.
        for (int i = 0; i <= insn_q.size(); i++) begin
            @(posedge clk_i);
            if (i < insn_q.size()) begin
                drive_row(i);
            end else begin
                drive_idle();
            end
            @(negedge clk_i);
            if (i > 0) begin
                predict_row(i - 1);
                check_outputs(i - 1);
            end
        end

        done = 1'b1;
        $display("checks done over %0d rows, %0d errors", insn_q.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!done) begin
            $display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/insn_match.sv
rtl/imm_gen.sv
rtl/uop_encode.sv
rtl/decode_ctrl.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/uop_pkg.sv
      - rtl/insn_match.sv
      - rtl/imm_gen.sv
      - rtl/uop_encode.sv
      - rtl/decode_ctrl.sv
      - rtl/decode_stage.sv
  - target: test
    files:
      - test/tb_decode_stage.sv
